//--- include/cheri_cap_defs.svh
`ifndef CHERI_CAP_DEFS_SVH
`define CHERI_CAP_DEFS_SVH

// width of an address and of every integer result
`define CHERI_INTEGER_SIZE 32

// object type width, the all-ones value marks an unsealed capability
`define CHERI_OTYPE_SIZE 4

// number of permission bits carried by a capability
`define CHERI_PERMS_SIZE 12

// one exception vector per operand, numbered as in the CHERI-RISC-V spec
`define CHERI_EXCEPTION_SIZE 22

// permission bit that lets a capability seal others
`define CHERI_PERMIT_SEAL_INDEX 7

// permission bit that lets a capability unseal others
`define CHERI_PERMIT_UNSEAL_INDEX 9

`endif

//--- source/cheri_cap_pkg.sv
`include "cheri_cap_defs.svh"

package cheri_cap_pkg;

  // otype value of a capability that is not sealed
  localparam logic [`CHERI_OTYPE_SIZE-1:0] OTYPE_UNSEALED = '1;

  // uncompressed capability, top is exclusive and one bit wider than base
  // so that a region may reach the end of the address space
  typedef struct packed {
    logic                           tag;
    logic [`CHERI_OTYPE_SIZE-1:0]   otype;
    logic                           flags;
    logic [`CHERI_PERMS_SIZE-1:0]   perms;
    logic [`CHERI_INTEGER_SIZE-1:0] base;
    logic [`CHERI_INTEGER_SIZE:0]   top;
    logic [`CHERI_INTEGER_SIZE-1:0] addr;
  } cap_t;

  // fields derived from one operand by the decoder
  typedef struct packed {
    logic                           sealed;
    logic [`CHERI_INTEGER_SIZE-1:0] offset;
    logic [`CHERI_INTEGER_SIZE:0]   length;
  } cap_fields_t;

  // value written back, wrote_cap is low when cap holds an integer
  typedef struct packed {
    cap_t cap;
    logic wrote_cap;
  } cap_result_t;

  typedef struct packed {
    logic [`CHERI_EXCEPTION_SIZE-1:0] exc_a;
    logic [`CHERI_EXCEPTION_SIZE-1:0] exc_b;
  } cap_exc_pair_t;

  // bit positions inside an exception vector
  typedef enum logic [4:0] {
    LENGTH_VIOLATION        = 5'd1,
    TAG_VIOLATION           = 5'd2,
    SEAL_VIOLATION          = 5'd3,
    TYPE_VIOLATION          = 5'd4,
    PERMIT_SEAL_VIOLATION   = 5'd11,
    PERMIT_UNSEAL_VIOLATION = 5'd12
  } cap_exc_e;

  // flat operation code, inspection first, then modification and sealing
  typedef enum logic [4:0] {
    C_GET_PERM,
    C_GET_TYPE,
    C_GET_BASE,
    C_GET_LEN,
    C_GET_TAG,
    C_GET_SEALED,
    C_GET_OFFSET,
    C_GET_FLAGS,
    C_GET_ADDR,
    C_MOVE,
    C_CLEAR_TAG,
    C_AND_PERM,
    C_SET_FLAGS,
    C_SET_ADDR,
    C_SET_OFFSET,
    C_INC_OFFSET,
    C_SET_BOUNDS,
    C_SEAL,
    C_UNSEAL
  } cap_op_e;

  // an integer travels as the null capability holding that address
  function automatic cap_t null_cap_with_addr(input logic [`CHERI_INTEGER_SIZE-1:0] addr);
    cap_t cap;
    cap = '0;
    cap.otype = OTYPE_UNSEALED;
    cap.addr = addr;
    return cap;
  endfunction

endpackage

//--- source/cap_field_decode.sv
`timescale 1ns/1ps
`include "cheri_cap_defs.svh"

module cap_field_decode (
  input  cheri_cap_pkg::cap_t        cap_i,
  output cheri_cap_pkg::cap_fields_t fields_o
);
  import cheri_cap_pkg::*;

  logic [`CHERI_INTEGER_SIZE:0] base_ext;

  // base widened to the width of top so the length keeps its carry bit
  assign base_ext = {1'b0, cap_i.base};

  always_comb begin
    // any otype other than all ones means the capability is sealed
    fields_o.sealed = (cap_i.otype != OTYPE_UNSEALED);

    // offset wraps modulo 2^32 when addr sits below base
    // the checker flags that case separately
    fields_o.offset = cap_i.addr - cap_i.base;

    // length is 33 bits wide so that a full 4 GiB region sets bit 32
    fields_o.length = cap_i.top - base_ext;
  end

endmodule

//--- source/cap_violation_check.sv
`timescale 1ns/1ps
`include "cheri_cap_defs.svh"

module cap_violation_check (
  input  cheri_cap_pkg::cap_op_e       op_i,
  input  cheri_cap_pkg::cap_t          cap_a_i,
  input  cheri_cap_pkg::cap_t          cap_b_i,
  input  cheri_cap_pkg::cap_fields_t   fields_a_i,
  input  cheri_cap_pkg::cap_fields_t   fields_b_i,
  output cheri_cap_pkg::cap_exc_pair_t exc_o
);
  import cheri_cap_pkg::*;

  // the all-ones otype is reserved for unsealed, so CSeal must stay below it
  localparam logic [`CHERI_INTEGER_SIZE-1:0] OTYPE_LIMIT =
    {{(`CHERI_INTEGER_SIZE-`CHERI_OTYPE_SIZE){1'b0}}, OTYPE_UNSEALED};

  // per-operand base conditions that every operation below shares
  logic untagged_a;
  logic untagged_b;
  logic tagged_sealed_a;
  logic tagged_sealed_b;
  logic below_base_a;
  logic below_base_b;
  logic at_top_b;
  logic no_seal_perm_b;
  logic no_unseal_perm_b;

  // extra terms that only one operation needs
  logic [`CHERI_INTEGER_SIZE:0]   new_top_a;
  logic                           otype_too_big_b;
  logic                           type_mismatch;

  assign untagged_a       = !cap_a_i.tag;
  assign untagged_b       = !cap_b_i.tag;
  assign tagged_sealed_a  = cap_a_i.tag && fields_a_i.sealed;
  assign tagged_sealed_b  = cap_b_i.tag && fields_b_i.sealed;
  assign below_base_a     = cap_a_i.addr < cap_a_i.base;
  assign below_base_b     = cap_b_i.addr < cap_b_i.base;
  assign at_top_b         = {1'b0, cap_b_i.addr} >= cap_b_i.top;
  assign no_seal_perm_b   = !cap_b_i.perms[`CHERI_PERMIT_SEAL_INDEX];
  assign no_unseal_perm_b = !cap_b_i.perms[`CHERI_PERMIT_UNSEAL_INDEX];

  // requested top of CSetBounds in 33 bits so the sum can never wrap
  assign new_top_a = {1'b0, cap_a_i.addr} + {1'b0, cap_b_i.addr};

  assign otype_too_big_b = cap_b_i.addr >= OTYPE_LIMIT;

  // CUnseal compares the key address against the sealed type of a
  assign type_mismatch =
    cap_b_i.addr != {{(`CHERI_INTEGER_SIZE-`CHERI_OTYPE_SIZE){1'b0}}, cap_a_i.otype};

  always_comb begin
    exc_o = '0;

    case (op_i)
      C_AND_PERM: begin
        exc_o.exc_a[TAG_VIOLATION]  = untagged_a;
        exc_o.exc_a[SEAL_VIOLATION] = tagged_sealed_a;
      end

      // these only change fields that an untagged capability may still carry
      C_SET_FLAGS, C_SET_ADDR, C_SET_OFFSET, C_INC_OFFSET: begin
        exc_o.exc_a[SEAL_VIOLATION] = tagged_sealed_a;
      end

      C_SET_BOUNDS: begin
        exc_o.exc_a[TAG_VIOLATION]    = untagged_a;
        exc_o.exc_a[SEAL_VIOLATION]   = tagged_sealed_a;
        // the new region has to lie inside the old one
        exc_o.exc_a[LENGTH_VIOLATION] = below_base_a || (new_top_a > cap_a_i.top);
      end

      C_SEAL: begin
        exc_o.exc_a[TAG_VIOLATION]         = untagged_a;
        exc_o.exc_a[SEAL_VIOLATION]        = tagged_sealed_a;
        // b is the sealing authority and its address is the otype to apply
        exc_o.exc_b[TAG_VIOLATION]         = untagged_b;
        exc_o.exc_b[SEAL_VIOLATION]        = tagged_sealed_b;
        exc_o.exc_b[LENGTH_VIOLATION]      = below_base_b || at_top_b || otype_too_big_b;
        exc_o.exc_b[PERMIT_SEAL_VIOLATION] = no_seal_perm_b;
      end

      C_UNSEAL: begin
        exc_o.exc_a[TAG_VIOLATION]           = untagged_a;
        // unsealing something that is not sealed is an error on a
        exc_o.exc_a[SEAL_VIOLATION]          = !fields_a_i.sealed;
        exc_o.exc_b[TAG_VIOLATION]           = untagged_b;
        exc_o.exc_b[SEAL_VIOLATION]          = fields_b_i.sealed;
        exc_o.exc_b[TYPE_VIOLATION]          = type_mismatch;
        exc_o.exc_b[PERMIT_UNSEAL_VIOLATION] = no_unseal_perm_b;
        exc_o.exc_b[LENGTH_VIOLATION]        = below_base_b || at_top_b;
      end

      // inspection, CMove and CClearTag never trap
      default: begin
        exc_o = '0;
      end
    endcase
  end

endmodule

//--- source/cap_result_build.sv
`timescale 1ns/1ps
`include "cheri_cap_defs.svh"

module cap_result_build (
  input  cheri_cap_pkg::cap_op_e     op_i,
  input  cheri_cap_pkg::cap_t        cap_a_i,
  input  cheri_cap_pkg::cap_t        cap_b_i,
  input  cheri_cap_pkg::cap_fields_t fields_a_i,
  input  cheri_cap_pkg::cap_fields_t fields_b_i,
  output cheri_cap_pkg::cap_result_t result_o
);
  import cheri_cap_pkg::*;

  // integer produced by the inspection operations
  logic [`CHERI_INTEGER_SIZE-1:0] int_val;
  logic                           is_int;

  // capability produced by the modification and sealing operations
  cap_t new_cap;

  // adders for the address updates and the new top of CSetBounds
  logic [`CHERI_INTEGER_SIZE-1:0] base_plus_b;
  logic [`CHERI_INTEGER_SIZE-1:0] addr_plus_b;
  logic [`CHERI_INTEGER_SIZE:0]   bounds_top;

  assign base_plus_b = cap_a_i.base + cap_b_i.addr;
  assign addr_plus_b = cap_a_i.addr + cap_b_i.addr;
  assign bounds_top  = {1'b0, cap_a_i.addr} + {1'b0, cap_b_i.addr};

  always_comb begin
    int_val = '0;
    is_int  = 1'b0;
    // every modification starts from operand a and patches one field
    new_cap = cap_a_i;

    case (op_i)
      C_GET_PERM: begin
        is_int  = 1'b1;
        int_val = {{(`CHERI_INTEGER_SIZE-`CHERI_PERMS_SIZE){1'b0}}, cap_a_i.perms};
      end
      C_GET_TYPE: begin
        is_int = 1'b1;
        // an unsealed capability reports -1 as its type
        if (fields_a_i.sealed) begin
          int_val = {{(`CHERI_INTEGER_SIZE-`CHERI_OTYPE_SIZE){1'b0}}, cap_a_i.otype};
        end else begin
          int_val = '1;
        end
      end
      C_GET_BASE: begin
        is_int  = 1'b1;
        int_val = cap_a_i.base;
      end
      C_GET_LEN: begin
        is_int = 1'b1;
        // a length of 2^32 does not fit, so it saturates
        if (fields_a_i.length[`CHERI_INTEGER_SIZE]) begin
          int_val = '1;
        end else begin
          int_val = fields_a_i.length[`CHERI_INTEGER_SIZE-1:0];
        end
      end
      C_GET_TAG: begin
        is_int  = 1'b1;
        int_val = {{(`CHERI_INTEGER_SIZE-1){1'b0}}, cap_a_i.tag};
      end
      C_GET_SEALED: begin
        is_int  = 1'b1;
        int_val = {{(`CHERI_INTEGER_SIZE-1){1'b0}}, fields_a_i.sealed};
      end
      C_GET_OFFSET: begin
        is_int  = 1'b1;
        int_val = fields_a_i.offset;
      end
      C_GET_FLAGS: begin
        is_int  = 1'b1;
        int_val = {{(`CHERI_INTEGER_SIZE-1){1'b0}}, cap_a_i.flags};
      end
      C_GET_ADDR: begin
        is_int  = 1'b1;
        int_val = cap_a_i.addr;
      end

      // CMove hands operand a through unchanged
      C_MOVE: begin
        new_cap = cap_a_i;
      end
      C_CLEAR_TAG: begin
        new_cap.tag = 1'b0;
      end
      C_AND_PERM: begin
        new_cap.perms = cap_a_i.perms & cap_b_i.addr[`CHERI_PERMS_SIZE-1:0];
      end
      C_SET_FLAGS: begin
        new_cap.flags = cap_b_i.addr[0];
      end
      C_SET_ADDR: begin
        new_cap.addr = cap_b_i.addr;
      end
      C_SET_OFFSET: begin
        new_cap.addr = base_plus_b;
      end
      C_INC_OFFSET: begin
        new_cap.addr = addr_plus_b;
      end
      C_SET_BOUNDS: begin
        // the region starts at the current address, b.addr is its length
        new_cap.base = cap_a_i.addr;
        new_cap.top  = bounds_top;
      end
      C_SEAL: begin
        new_cap.otype = cap_b_i.addr[`CHERI_OTYPE_SIZE-1:0];
      end
      C_UNSEAL: begin
        new_cap.otype = OTYPE_UNSEALED;
      end

      // unused encodings write a zero integer
      default: begin
        is_int  = 1'b1;
        int_val = '0;
      end
    endcase
  end

  always_comb begin
    result_o.wrote_cap = !is_int;
    if (is_int) begin
      result_o.cap = null_cap_with_addr(int_val);
    end else begin
      result_o.cap = new_cap;
    end
  end

endmodule

//--- source/cap_result_reg.sv
`timescale 1ns/1ps

module cap_result_reg (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         req_i,
  input  cheri_cap_pkg::cap_result_t   result_i,
  input  cheri_cap_pkg::cap_exc_pair_t exc_i,
  output logic                         valid_o,
  output cheri_cap_pkg::cap_result_t   result_o,
  output cheri_cap_pkg::cap_exc_pair_t exc_o
);

  // valid follows the request by exactly one cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= req_i;
    end
  end

  // payload is held between requests so the last result stays visible
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_o <= '0;
      exc_o    <= '0;
    end else if (req_i) begin
      result_o <= result_i;
      exc_o    <= exc_i;
    end
  end

endmodule

//--- source/cheri_cap_alu.sv
`timescale 1ns/1ps

module cheri_cap_alu (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         req_i,
  input  cheri_cap_pkg::cap_op_e       op_i,
  input  cheri_cap_pkg::cap_t          cap_a_i,
  input  cheri_cap_pkg::cap_t          cap_b_i,
  output logic                         valid_o,
  output cheri_cap_pkg::cap_result_t   result_o,
  output cheri_cap_pkg::cap_exc_pair_t exc_o
);
  import cheri_cap_pkg::*;

  cap_fields_t   fields_a;
  cap_fields_t   fields_b;
  cap_exc_pair_t exc_comb;
  cap_result_t   result_comb;

  // one field decoder per operand
  cap_field_decode i_decode_a (
    .cap_i    (cap_a_i),
    .fields_o (fields_a)
  );

  cap_field_decode i_decode_b (
    .cap_i    (cap_b_i),
    .fields_o (fields_b)
  );

  // checker and builder run in parallel on the same decoded operands
  cap_violation_check i_violation_check (
    .op_i       (op_i),
    .cap_a_i    (cap_a_i),
    .cap_b_i    (cap_b_i),
    .fields_a_i (fields_a),
    .fields_b_i (fields_b),
    .exc_o      (exc_comb)
  );

  cap_result_build i_result_build (
    .op_i       (op_i),
    .cap_a_i    (cap_a_i),
    .cap_b_i    (cap_b_i),
    .fields_a_i (fields_a),
    .fields_b_i (fields_b),
    .result_o   (result_comb)
  );

  // single register stage, the execute stage boundary
  cap_result_reg i_result_reg (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (req_i),
    .result_i (result_comb),
    .exc_i    (exc_comb),
    .valid_o  (valid_o),
    .result_o (result_o),
    .exc_o    (exc_o)
  );

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  // free-running clock, first rising edge half a period after time zero
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

//--- verification/cheri_cap_alu_properties.sv
`timescale 1ns/1ps
`include "cheri_cap_defs.svh"

module cheri_cap_alu_properties (
  input logic                         clk_i,
  input logic                         rst_n_i,
  input logic                         req_i,
  input logic                         valid_o,
  input cheri_cap_pkg::cap_exc_pair_t exc_o
);
  import cheri_cap_pkg::*;

  // only the architected exception positions may ever be raised
  function automatic logic [`CHERI_EXCEPTION_SIZE-1:0] legal_exc_mask();
    logic [`CHERI_EXCEPTION_SIZE-1:0] m;
    m = '0;
    m[LENGTH_VIOLATION]        = 1'b1;
    m[TAG_VIOLATION]           = 1'b1;
    m[SEAL_VIOLATION]          = 1'b1;
    m[TYPE_VIOLATION]          = 1'b1;
    m[PERMIT_SEAL_VIOLATION]   = 1'b1;
    m[PERMIT_UNSEAL_VIOLATION] = 1'b1;
    return m;
  endfunction

  localparam logic [`CHERI_EXCEPTION_SIZE-1:0] EXC_LEGAL = legal_exc_mask();

  // one register stage, so valid is the request of the cycle before
  valid_follows_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) valid_o == $past(req_i)
  ) else $error("valid_o does not match req_i of the previous cycle");

  valid_low_in_reset: assert property (
    @(posedge clk_i) !rst_n_i |-> !valid_o
  ) else $error("valid_o is high while reset is asserted");

  exc_bits_legal: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) ((exc_o.exc_a | exc_o.exc_b) & ~EXC_LEGAL) == '0
  ) else $error("an exception bit outside the defined positions is set");

endmodule

bind cheri_cap_alu cheri_cap_alu_properties i_properties (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .req_i   (req_i),
  .valid_o (valid_o),
  .exc_o   (exc_o)
);

//--- verification/cheri_cap_alu_tb.sv
`timescale 1ns/1ps
`include "cheri_cap_defs.svh"

module cheri_cap_alu_tb;
  import cheri_cap_pkg::*;

  localparam int          CLK_PERIOD_NS = 100;
  localparam int          RESET_CYCLES  = 16;
  localparam int          NUM_RANDOM    = 300;
  localparam logic [31:0] LFSR_SEED     = 32'h7bf5_b388;

  // one request as it is replayed where gap counts the idle cycles before it
  typedef struct packed {
    cap_op_e    op;
    cap_t       a;
    cap_t       b;
    logic [1:0] gap;
  } stim_t;

  // scoreboard entry for one request
  typedef struct packed {
    cap_op_e       op;
    cap_result_t   res;
    cap_exc_pair_t exc;
  } expect_t;

  logic          clk;
  logic          rst_n;
  logic          req;
  cap_op_e       op;
  cap_t          cap_a;
  cap_t          cap_b;
  logic          valid;
  cap_result_t   result;
  cap_exc_pair_t exc;

  stim_t       stim_q[$];
  expect_t     exp_q[$];
  logic [31:0] lfsr_state;
  logic        req_prev;
  int          result_errors;
  int          exc_errors;
  int          protocol_errors;
  int          checked;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) i_clock_gen (.clk_o(clk));

  cheri_cap_alu i_dut (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .req_i    (req),
    .op_i     (op),
    .cap_a_i  (cap_a),
    .cap_b_i  (cap_b),
    .valid_o  (valid),
    .result_o (result),
    .exc_o    (exc)
  );

  // Galois LFSR with the polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // takes n bits with one LFSR step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic cap_t make_cap(input logic tag, input logic [3:0] otype,
                                    input logic flags, input logic [11:0] perms,
                                    input logic [31:0] base, input logic [32:0] top,
                                    input logic [31:0] addr);
    cap_t c;
    c.tag   = tag;
    c.otype = otype;
    c.flags = flags;
    c.perms = perms;
    c.base  = base;
    c.top   = top;
    c.addr  = addr;
    return c;
  endfunction

  // an integer result is the null capability carrying that value as address
  function automatic cap_t int_in_null_cap(input logic [31:0] value);
    return make_cap(1'b0, 4'hF, 1'b0, 12'h000, 32'd0, 33'd0, value);
  endfunction

  function automatic logic is_inspection(input cap_op_e o);
    return o inside {C_GET_PERM, C_GET_TYPE, C_GET_BASE, C_GET_LEN, C_GET_TAG,
                     C_GET_SEALED, C_GET_OFFSET, C_GET_FLAGS, C_GET_ADDR};
  endfunction

  function automatic cap_result_t ref_result(input cap_op_e o, input cap_t a, input cap_t b);
    cap_result_t r;
    logic        sealed_a;
    logic [32:0] len_a;
    sealed_a = (a.otype != 4'hF);
    len_a    = a.top - {1'b0, a.base};
    r.cap    = a;
    case (o)
      C_GET_PERM:   r.cap = int_in_null_cap({20'd0, a.perms});
      C_GET_TYPE:   r.cap = int_in_null_cap(sealed_a ? {28'd0, a.otype} : 32'hFFFF_FFFF);
      C_GET_BASE:   r.cap = int_in_null_cap(a.base);
      // lengths of 2^32 and above do not fit in 32 bits
      C_GET_LEN:    r.cap = int_in_null_cap(len_a[32] ? 32'hFFFF_FFFF : len_a[31:0]);
      C_GET_TAG:    r.cap = int_in_null_cap({31'd0, a.tag});
      C_GET_SEALED: r.cap = int_in_null_cap({31'd0, sealed_a});
      C_GET_OFFSET: r.cap = int_in_null_cap(a.addr - a.base);
      C_GET_FLAGS:  r.cap = int_in_null_cap({31'd0, a.flags});
      C_GET_ADDR:   r.cap = int_in_null_cap(a.addr);
      C_MOVE:       r.cap = a;
      C_CLEAR_TAG:  r.cap.tag = 1'b0;
      C_AND_PERM:   r.cap.perms = a.perms & b.addr[11:0];
      C_SET_FLAGS:  r.cap.flags = b.addr[0];
      C_SET_ADDR:   r.cap.addr = b.addr;
      C_SET_OFFSET: r.cap.addr = a.base + b.addr;
      C_INC_OFFSET: r.cap.addr = a.addr + b.addr;
      C_SET_BOUNDS: begin
        r.cap.base = a.addr;
        r.cap.top  = {1'b0, a.addr} + {1'b0, b.addr};
      end
      C_SEAL:       r.cap.otype = b.addr[3:0];
      C_UNSEAL:     r.cap.otype = 4'hF;
      default:      r.cap = int_in_null_cap(32'd0);
    endcase
    r.wrote_cap = !is_inspection(o);
    return r;
  endfunction

  function automatic cap_exc_pair_t ref_exc(input cap_op_e o, input cap_t a, input cap_t b);
    cap_exc_pair_t e;
    logic          sealed_a;
    logic          sealed_b;
    logic          out_of_bounds_b;
    logic [32:0]   req_top;
    e               = '0;
    sealed_a        = (a.otype != 4'hF);
    sealed_b        = (b.otype != 4'hF);
    out_of_bounds_b = (b.addr < b.base) || ({1'b0, b.addr} >= b.top);
    req_top         = {1'b0, a.addr} + {1'b0, b.addr};
    case (o)
      C_AND_PERM, C_SET_BOUNDS, C_SEAL: begin
        e.exc_a[TAG_VIOLATION]  = !a.tag;
        e.exc_a[SEAL_VIOLATION] = a.tag && sealed_a;
      end
      C_SET_FLAGS, C_SET_ADDR, C_SET_OFFSET, C_INC_OFFSET: begin
        e.exc_a[SEAL_VIOLATION] = a.tag && sealed_a;
      end
      C_UNSEAL: begin
        e.exc_a[TAG_VIOLATION]           = !a.tag;
        e.exc_a[SEAL_VIOLATION]          = !sealed_a;
        e.exc_b[TAG_VIOLATION]           = !b.tag;
        e.exc_b[SEAL_VIOLATION]          = sealed_b;
        e.exc_b[TYPE_VIOLATION]          = b.addr != {28'd0, a.otype};
        e.exc_b[PERMIT_UNSEAL_VIOLATION] = !b.perms[`CHERI_PERMIT_UNSEAL_INDEX];
        e.exc_b[LENGTH_VIOLATION]        = out_of_bounds_b;
      end
      default: begin
        e = '0;
      end
    endcase
    // the bounds and sealer terms that add to the shared tag and seal checks
    if (o == C_SET_BOUNDS) begin
      e.exc_a[LENGTH_VIOLATION] = (a.addr < a.base) || (req_top > a.top);
    end
    if (o == C_SEAL) begin
      e.exc_b[TAG_VIOLATION]         = !b.tag;
      e.exc_b[SEAL_VIOLATION]        = b.tag && sealed_b;
      e.exc_b[LENGTH_VIOLATION]      = out_of_bounds_b || (b.addr >= 32'd15);
      e.exc_b[PERMIT_SEAL_VIOLATION] = !b.perms[`CHERI_PERMIT_SEAL_INDEX];
    end
    return e;
  endfunction

  task automatic check_result(input cap_op_e o, input cap_result_t got, input cap_result_t want);
    if (got !== want) begin
      result_errors++;
      $display("error: result_o for %s got %h expected %h", o.name(), got, want);
    end
  endtask

  task automatic check_exc(input cap_op_e o, input cap_exc_pair_t got, input cap_exc_pair_t want);
    if (got !== want) begin
      exc_errors++;
      $display("error: exc_o for %s got exc_a %h exc_b %h expected exc_a %h exc_b %h",
               o.name(), got.exc_a, got.exc_b, want.exc_a, want.exc_b);
    end
  endtask

  task automatic add_req(input cap_op_e o, input cap_t a, input cap_t b, input logic [1:0] gap);
    stim_t s;
    s.op  = o;
    s.a   = a;
    s.b   = b;
    s.gap = gap;
    stim_q.push_back(s);
  endtask

  // directed cases run back to back, which also covers the one-cycle latency
  task automatic build_directed();
    cap_t plain;
    cap_t sealed5;
    cap_t full;
    cap_t sealer;
    cap_t t;
    plain   = make_cap(1'b1, 4'hF, 1'b1, 12'hABC, 32'h1000, 33'h2000, 32'h1800);
    sealed5 = plain;
    sealed5.otype = 4'h5;
    full    = make_cap(1'b1, 4'hF, 1'b0, 12'hFFF, 32'h0, 33'h1_0000_0000, 32'hFFFF_FF00);
    sealer  = make_cap(1'b1, 4'hF, 1'b0, 12'h280, 32'd0, 33'd16, 32'd5);
    // all nine inspections on an unsealed capability
    for (int i = 0; i <= 8; i++) begin
      add_req(cap_op_e'(5'(i)), plain, int_in_null_cap(32'd0), 2'd0);
    end
    add_req(C_GET_LEN, full, plain, 2'd0);
    add_req(C_GET_TYPE, sealed5, plain, 2'd0);
    add_req(C_GET_SEALED, sealed5, plain, 2'd0);
    t = plain;
    t.addr = 32'h800;
    add_req(C_GET_OFFSET, t, plain, 2'd0);
    // modification operations clean and with seal or tag faults
    add_req(C_MOVE, sealed5, plain, 2'd0);
    add_req(C_CLEAR_TAG, plain, plain, 2'd0);
    add_req(C_AND_PERM, plain, int_in_null_cap(32'h0F0), 2'd0);
    add_req(C_AND_PERM, sealed5, int_in_null_cap(32'h0F0), 2'd0);
    t = plain;
    t.tag = 1'b0;
    add_req(C_AND_PERM, t, int_in_null_cap(32'h0F0), 2'd0);
    add_req(C_SET_ADDR, t, int_in_null_cap(32'hDEAD_BEEF), 2'd0);
    add_req(C_SET_FLAGS, plain, int_in_null_cap(32'd0), 2'd0);
    add_req(C_SET_FLAGS, sealed5, int_in_null_cap(32'd1), 2'd0);
    add_req(C_SET_OFFSET, plain, int_in_null_cap(32'h40), 2'd0);
    add_req(C_INC_OFFSET, sealed5, int_in_null_cap(32'h40), 2'd0);
    t = plain;
    t.addr = 32'hFFFF_FFF0;
    add_req(C_INC_OFFSET, t, int_in_null_cap(32'h20), 2'd0);
    // bounds inside, past top, below base, and reaching exactly 2^32
    add_req(C_SET_BOUNDS, plain, int_in_null_cap(32'h100), 2'd0);
    add_req(C_SET_BOUNDS, plain, int_in_null_cap(32'h900), 2'd0);
    t = plain;
    t.addr = 32'h800;
    add_req(C_SET_BOUNDS, t, int_in_null_cap(32'h10), 2'd0);
    add_req(C_SET_BOUNDS, full, int_in_null_cap(32'h100), 2'd0);
    // sealing with each violation provoked on its own
    add_req(C_SEAL, plain, sealer, 2'd0);
    add_req(C_SEAL, sealed5, sealer, 2'd0);
    t = sealer;
    t.perms = 12'h200;
    add_req(C_SEAL, plain, t, 2'd0);
    t = sealer;
    t.tag = 1'b0;
    add_req(C_SEAL, plain, t, 2'd0);
    t = sealer;
    t.otype = 4'h3;
    add_req(C_SEAL, plain, t, 2'd0);
    add_req(C_UNSEAL, sealed5, t, 2'd0);
    t = sealer;
    t.top  = 33'd64;
    t.addr = 32'd15;
    add_req(C_SEAL, plain, t, 2'd0);
    add_req(C_UNSEAL, plain, t, 2'd0);
    add_req(C_UNSEAL, sealed5, sealer, 2'd0);
    t = sealer;
    t.addr = 32'd6;
    add_req(C_UNSEAL, sealed5, t, 2'd0);
    t = sealer;
    t.perms = 12'h080;
    add_req(C_UNSEAL, sealed5, t, 2'd0);
    t = sealer;
    t.base = 32'd8;
    add_req(C_UNSEAL, sealed5, t, 2'd0);
  endtask

  // base is never above top and addr is scattered around base
  function automatic cap_t random_cap();
    cap_t        c;
    logic [31:0] len;
    logic [32:0] top_ext;
    c.tag   = (rand_bits(2) != 32'd0);
    c.otype = (rand_bits(1) != 32'd0) ? 4'hF : 4'(rand_bits(4));
    c.flags = 1'(rand_bits(1));
    c.perms = 12'(rand_bits(12));
    c.base  = rand_bits(32);
    len     = (rand_bits(2) == 32'd0) ? rand_bits(32) : rand_bits(12);
    top_ext = {1'b0, c.base} + {1'b0, len};
    if (top_ext > 33'h1_0000_0000) begin
      top_ext = 33'h1_0000_0000;
    end
    c.top  = top_ext;
    c.addr = c.base + rand_bits(13) - 32'd512;
    return c;
  endfunction

  task automatic build_random();
    cap_op_e    o;
    cap_t       a;
    cap_t       b;
    logic [1:0] gap;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      o = cap_op_e'(5'(rand_bits(5) % 32'd19));
      a = random_cap();
      b = random_cap();
      // small b addresses hit otypes and short lengths more often
      if (rand_bits(1) != 32'd0) begin
        b.addr = rand_bits(8);
      end
      if (o == C_UNSEAL && rand_bits(1) != 32'd0) begin
        b.addr = {28'd0, a.otype};
      end
      gap = (rand_bits(2) == 32'd0) ? 2'(rand_bits(2)) : 2'd0;
      add_req(o, a, b, gap);
    end
  endtask

  initial begin : stimulus
    stim_t   s;
    expect_t e;
    int      total;
    rst_n      = 1'b0;
    req        = 1'b0;
    op         = C_GET_PERM;
    cap_a      = '0;
    cap_b      = '0;
    lfsr_state = LFSR_SEED;
    build_directed();
    build_random();
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    // valid_o has to stay low during the idle lead-in before the first request
    repeat (3) @(posedge clk);
    for (int i = 0; i < stim_q.size(); i++) begin
      s = stim_q[i];
      repeat (s.gap) begin
        @(posedge clk);
        req <= 1'b0;
      end
      @(posedge clk);
      req   <= 1'b1;
      op    <= s.op;
      cap_a <= s.a;
      cap_b <= s.b;
      e.op  = s.op;
      e.res = ref_result(s.op, s.a, s.b);
      e.exc = ref_exc(s.op, s.a, s.b);
      exp_q.push_back(e);
    end
    @(posedge clk);
    req <= 1'b0;
    // latency is exactly one cycle, so the last result is in by now
    repeat (2) @(posedge clk);
    if (checked != stim_q.size()) begin
      protocol_errors++;
      $display("only %0d of %0d requests produced a result", checked, stim_q.size());
    end
    total = result_errors + exc_errors + protocol_errors;
    $display("errors: result %0d, exceptions %0d, protocol %0d",
             result_errors, exc_errors, protocol_errors);
    if (total == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // outputs settle after the rising edge, so they are sampled on the falling one
  always @(negedge clk) begin
    expect_t e;
    if (!rst_n) begin
      if (valid !== 1'b0) begin
        protocol_errors++;
        $display("valid_o was high while reset was asserted at %0t", $time);
      end
      req_prev = 1'b0;
    end else begin
      if (valid !== req_prev) begin
        protocol_errors++;
        $display("valid_o did not follow req_i by exactly one cycle at %0t", $time);
      end
      if (valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          protocol_errors++;
          $display("valid_o was high with no request outstanding at %0t", $time);
        end else begin
          e = exp_q.pop_front();
          check_result(e.op, result, e.res);
          check_exc(e.op, exc, e.exc);
          checked++;
        end
      end
      req_prev = req;
    end
  end

  initial begin : watchdog
    int cycles;
    #1;
    // reset, lead-in, every request with its gap, then a margin for the drain
    cycles = RESET_CYCLES + 3 + 40;
    foreach (stim_q[i]) begin
      cycles += int'(stim_q[i].gap) + 1;
    end
    #(cycles * CLK_PERIOD_NS);
    $display("timeout: the run did not finish within %0d cycles", cycles);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- sources.f
+incdir+include
source/cheri_cap_pkg.sv
source/cap_field_decode.sv
source/cap_violation_check.sv
source/cap_result_build.sv
source/cap_result_reg.sv
source/cheri_cap_alu.sv
verification/tb_clock_gen.sv
verification/cheri_cap_alu_properties.sv
verification/cheri_cap_alu_tb.sv

//--- Makefile
# Verilator flow for the CHERI capability ALU testbench

SHELL := /bin/bash

VERILATOR ?= verilator
TOP       ?= cheri_cap_alu_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= RESULT: FAIL

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
